// ==== sim/sdram_model.sv ====
module sdram_model #(
  parameter int CAS_LAT = 2
) (
  input  logic                               clk_i,
  input  sdram_sched_pkg::sdram_cmd_e        cmd_i,
  input  logic [sdram_sched_pkg::BA_W-1:0]   ba_i,
  input  logic [sdram_sched_pkg::ROW_W-1:0]  addr_i,
  input  logic [sdram_sched_pkg::DQ_W-1:0]   dq_i,
  input  logic                               dqoe_i,
  output logic [sdram_sched_pkg::DQ_W-1:0]   dq_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int KEY_W = sdram_sched_pkg::BA_W + sdram_sched_pkg::ROW_W
                         + sdram_sched_pkg::COL_W;

  // Unwritten locations read as zero
  logic [sdram_sched_pkg::DQ_W-1:0]  mem      [logic [KEY_W-1:0]];
  logic [sdram_sched_pkg::ROW_W-1:0] open_row [sdram_sched_pkg::BANKS];
  logic [sdram_sched_pkg::DQ_W-1:0]  pipe     [CAS_LAT] = '{default: '0};

  always @(posedge clk_i)
  begin
    logic [KEY_W-1:0] key;
    key = {ba_i, open_row[ba_i], addr_i[sdram_sched_pkg::COL_W-1:0]};
    if (cmd_i == sdram_sched_pkg::ACT)
      open_row[ba_i] = addr_i;
    if ((cmd_i == sdram_sched_pkg::WR) && dqoe_i)
      mem[key] = dq_i;

    // Read data walks CAS_LAT cycles to the pins
    for (int s = CAS_LAT - 1; s > 0; s--)
      pipe[s] <= pipe[s-1];
    if (cmd_i == sdram_sched_pkg::RD)
      pipe[0] <= mem.exists(key) ? mem[key] : '0;
    else
      pipe[0] <= '0;
  end

  assign dq_o = pipe[CAS_LAT-1];

endmodule

// ==== sim/sdram_sched_asserts.sv ====
module sdram_sched_asserts #(
  parameter int PORTS = 2,
  parameter int T_RCD = 2,
  parameter int T_RC  = 7
) (
  input logic                              clk_i,
  input logic                              rst_ni,
  input logic [PORTS-1:0]                  req_i,
  input logic [PORTS-1:0]                  ack_o,
  input sdram_sched_pkg::sdram_cmd_e       sdram_cmd_o,
  input logic [sdram_sched_pkg::BA_W-1:0]  sdram_ba_o,
  input logic                              sdram_dqoe_o
);

  timeunit 1ns;
  timeprecision 1ps;

  int   fail_count = 0;
  logic is_act;
  logic is_rdwr;

  assign is_act  = (sdram_cmd_o == sdram_sched_pkg::ACT);
  assign is_rdwr = (sdram_cmd_o == sdram_sched_pkg::RD) || (sdram_cmd_o == sdram_sched_pkg::WR);

  ////////////////////////////////////////////////////////////////////////////
  // Bank timing
  ////////////////////////////////////////////////////////////////////////////

  for (genvar d = 1; d < T_RCD; d++)
  begin : g_rcd
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      is_rdwr |-> !($past(is_act, d) && ($past(sdram_ba_o, d) == sdram_ba_o)))
    else
    begin
      $error("RD or WR to bank %0d only %0d cycles after ACT", sdram_ba_o, d);
      fail_count++;
    end
  end

  for (genvar d = 1; d < T_RC; d++)
  begin : g_rc
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      is_act |-> !($past(is_act, d) && ($past(sdram_ba_o, d) == sdram_ba_o)))
    else
    begin
      $error("Two ACTs to bank %0d only %0d cycles apart", sdram_ba_o, d);
      fail_count++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake and data enable
  ////////////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < PORTS; p++)
  begin : g_ack
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(ack_o[p]) |-> req_i[p])
    else
    begin
      $error("ack of port %0d rose while req was low", p);
      fail_count++;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    sdram_dqoe_o |-> (sdram_cmd_o == sdram_sched_pkg::WR))
  else
  begin
    $error("DQ output enable high outside a WR cycle");
    fail_count++;
  end

endmodule

// ==== sim/tb_sdram_sched.sv ====
module tb_sdram_sched;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PORTS        = 2;
  localparam int T_RCD        = 2;
  localparam int T_RP         = 3;
  localparam int T_WR         = 2;
  localparam int T_RC         = 7;
  localparam int T_RFC        = 8;
  localparam int CAS_LAT      = 2;
  localparam int REF_INTERVAL = 400;
  localparam int TXNS         = 60;
  localparam int WATCHDOG_CYC = 2 * TXNS * 40 + 1000;
  localparam int BA_W         = sdram_sched_pkg::BA_W;
  localparam int ROW_W        = sdram_sched_pkg::ROW_W;
  localparam int COL_W        = sdram_sched_pkg::COL_W;
  localparam int DQ_W         = sdram_sched_pkg::DQ_W;
  localparam int KEY_W        = BA_W + ROW_W + COL_W;

  logic                        clk;
  logic                        rst_n;
  logic [PORTS-1:0]            req;
  logic [PORTS-1:0]            we;
  logic [BA_W-1:0]             ba    [PORTS];
  logic [ROW_W-1:0]            row   [PORTS];
  logic [COL_W-1:0]            col   [PORTS];
  logic [DQ_W-1:0]             wdata [PORTS];
  logic [PORTS-1:0]            ack;
  logic [PORTS-1:0]            rvalid;
  logic [DQ_W-1:0]             rdata;
  sdram_sched_pkg::sdram_cmd_e sdram_cmd;
  logic [BA_W-1:0]             sdram_ba;
  logic [ROW_W-1:0]            sdram_addr;
  logic [DQ_W-1:0]             sdram_dq_out;
  logic                        sdram_dqoe;
  logic [DQ_W-1:0]             sdram_dq_in;

  // Stimulus tables, one row per port
  logic            t_we    [PORTS][TXNS];
  logic [BA_W-1:0] t_ba    [PORTS][TXNS];
  logic [ROW_W-1:0] t_row  [PORTS][TXNS];
  logic [COL_W-1:0] t_col  [PORTS][TXNS];
  logic [DQ_W-1:0] t_wdata [PORTS][TXNS];
  int              t_gap   [PORTS][TXNS];
  int              reads_exp [PORTS];

  // Reference memory and expected read returns
  logic [DQ_W-1:0] ref_mem [logic [KEY_W-1:0]];
  int              due_q   [PORTS][$];
  logic [DQ_W-1:0] data_q  [PORTS][$];

  logic [31:0]      rng_state = 32'd87653;
  int               cyc = 0;
  int               check_count = 0;
  int               error_count = 0;
  int               ref_count = 0;
  int               last_ref = 0;
  int               ack_count    [PORTS];
  int               rvalid_count [PORTS];
  int               start_cyc    [PORTS];
  logic [PORTS-1:0] ack_prev;
  logic [PORTS-1:0] req_prev;

  sdram_sched_top #(
    .PORTS        (PORTS),
    .T_RCD        (T_RCD),
    .T_RP         (T_RP),
    .T_WR         (T_WR),
    .T_RC         (T_RC),
    .T_RFC        (T_RFC),
    .CAS_LAT      (CAS_LAT),
    .REF_INTERVAL (REF_INTERVAL)
  ) DUT (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_i        (req),
    .we_i         (we),
    .ba_i         (ba),
    .row_i        (row),
    .col_i        (col),
    .wdata_i      (wdata),
    .ack_o        (ack),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .sdram_cmd_o  (sdram_cmd),
    .sdram_ba_o   (sdram_ba),
    .sdram_addr_o (sdram_addr),
    .sdram_dq_o   (sdram_dq_out),
    .sdram_dqoe_o (sdram_dqoe),
    .sdram_dq_i   (sdram_dq_in)
  );

  sdram_model #(
    .CAS_LAT (CAS_LAT)
  ) u_memory (
    .clk_i  (clk),
    .cmd_i  (sdram_cmd),
    .ba_i   (sdram_ba),
    .addr_i (sdram_addr),
    .dq_i   (sdram_dq_out),
    .dqoe_i (sdram_dqoe),
    .dq_o   (sdram_dq_in)
  );

  bind sdram_sched_top sdram_sched_asserts #(
    .PORTS (PORTS),
    .T_RCD (T_RCD),
    .T_RC  (T_RC)
  ) u_asserts (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .ack_o        (ack_o),
    .sdram_cmd_o  (sdram_cmd_o),
    .sdram_ba_o   (sdram_ba_o),
    .sdram_dqoe_o (sdram_dqoe_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("** Error: %s expected %0h actual %0h at cycle %0d",
               name, expected, actual, cyc);
    end
  endtask

  // Small row set and few columns so addresses repeat
  task automatic build_stimulus();
    for (int p = 0; p < PORTS; p++)
    begin
      reads_exp[p] = 0;
      for (int i = 0; i < TXNS; i++)
      begin
        t_we[p][i]    = next_random() % 2;
        t_ba[p][i]    = next_random() % 4;
        t_row[p][i]   = 12'h155 * (next_random() % 3);
        t_col[p][i]   = next_random() % 8;
        t_wdata[p][i] = next_random();
        t_gap[p][i]   = (i == 0) ? 0 : next_random() % 4;
        if (!t_we[p][i])
          reads_exp[p]++;
      end
    end
  endtask

  // Four-phase client
  task automatic drive_port(input int p);
    for (int i = 0; i < TXNS; i++)
    begin
      repeat (t_gap[p][i]) @(posedge clk);
      req[p]   <= 1'b1;
      we[p]    <= t_we[p][i];
      ba[p]    <= t_ba[p][i];
      row[p]   <= t_row[p][i];
      col[p]   <= t_col[p][i];
      wdata[p] <= t_wdata[p][i];
      do @(posedge clk); while (!ack[p]);
      req[p] <= 1'b0;
      do @(posedge clk); while (ack[p]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, watchdog and monitor
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Timeout: client traffic did not complete within %0d cycles", WATCHDOG_CYC);
    $display("TEST FAILED");
    $finish;
  end

  always @(posedge clk)
  begin
    logic [PORTS-1:0] ack_rise;
    logic             is_rdwr;
    logic [KEY_W-1:0] key;
    if (!rst_n)
    begin
      ack_prev = '0;
      req_prev = '0;
    end
    else
    begin
      cyc++;
      ack_rise = ack & ~ack_prev;
      is_rdwr  = (sdram_cmd == sdram_sched_pkg::RD) || (sdram_cmd == sdram_sched_pkg::WR);

      // Refresh count and tRFC spacing
      if (sdram_cmd == sdram_sched_pkg::REF)
      begin
        ref_count++;
        last_ref = cyc;
      end
      if ((sdram_cmd == sdram_sched_pkg::ACT) && (ref_count != 0))
        check_value("ACT after REF spacing", 1, (cyc - last_ref) >= T_RFC);

      for (int p = 0; p < PORTS; p++)
      begin
        if (req[p] && !req_prev[p])
          start_cyc[p] = cyc;
      end

      // Every RD or WR comes with exactly one ack rise
      check_value("ack rise with RD or WR", is_rdwr, ack_rise != '0);
      check_value("single ack rise", 1, $countones(ack_rise) <= 1);

      for (int p = 0; p < PORTS; p++)
      begin
        if (ack_rise[p])
        begin
          ack_count[p]++;
          key = {ba[p], row[p], col[p]};
          check_value("command direction", we[p] ? sdram_sched_pkg::WR : sdram_sched_pkg::RD,
                      sdram_cmd);
          check_value("command bank", ba[p], sdram_ba);
          check_value("command column", col[p], sdram_addr[COL_W-1:0]);
          check_value("auto-precharge bit", 1, sdram_addr[sdram_sched_pkg::AP_BIT]);
          if (p == 1)
            check_value("port 0 priority", 0,
                        req[0] && !ack[0] && (start_cyc[0] == start_cyc[1]));
          if (we[p])
          begin
            check_value("write data", wdata[p], sdram_dq_out);
            check_value("write enable", 1, sdram_dqoe);
            ref_mem[key] = wdata[p];
          end
          else
          begin
            due_q[p].push_back(cyc + CAS_LAT + 1);
            data_q[p].push_back(ref_mem.exists(key) ? ref_mem[key] : '0);
          end
        end

        // Read return
        if (rvalid[p])
        begin
          rvalid_count[p]++;
          if (due_q[p].size() == 0)
          begin
            check_value("rvalid without read", 0, 1);
          end
          else
          begin
            check_value("read return cycle", due_q[p][0], cyc);
            check_value("read data", data_q[p][0], rdata);
            void'(due_q[p].pop_front());
            void'(data_q[p].pop_front());
          end
        end
        else if ((due_q[p].size() != 0) && (due_q[p][0] == cyc))
        begin
          check_value("missing rvalid", 1, 0);
          void'(due_q[p].pop_front());
          void'(data_q[p].pop_front());
        end
      end

      ack_prev = ack;
      req_prev = req;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int total;
    int ref_exp;
    rst_n = 1'b0;
    req   = '0;
    we    = '0;
    for (int p = 0; p < PORTS; p++)
    begin
      ba[p]           = '0;
      row[p]          = '0;
      col[p]          = '0;
      wdata[p]        = '0;
      ack_count[p]    = 0;
      rvalid_count[p] = 0;
      start_cyc[p]    = 0;
    end
    build_stimulus();

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    fork
      drive_port(0);
      drive_port(1);
    join

    // Let reads still in flight come back
    while ((due_q[0].size() != 0) || (due_q[1].size() != 0))
      @(posedge clk);
    repeat (2) @(posedge clk);

    // Idle until several refresh intervals have elapsed
    while (cyc < 3 * REF_INTERVAL)
      @(posedge clk);

    for (int p = 0; p < PORTS; p++)
    begin
      check_value("ack count", TXNS, ack_count[p]);
      check_value("rvalid count", reads_exp[p], rvalid_count[p]);
    end
    ref_exp = cyc / REF_INTERVAL;
    check_value("refresh count", 1, (ref_count >= ref_exp - 1) && (ref_count <= ref_exp + 1));

    total = error_count + DUT.u_asserts.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d, refreshes: %0d",
             check_count, error_count, DUT.u_asserts.fail_count, ref_count);
    if (total == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== src/sdram_bank_timers.sv ====
module sdram_bank_timers #(
  parameter int T_RCD = 2,
  parameter int T_RP  = 3,
  parameter int T_WR  = 2,
  parameter int T_RC  = 7,
  parameter int T_RFC = 8
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               act_i,
  input  logic                               rdwr_i,
  input  logic                               is_write_i,
  input  logic                               ref_i,
  input  logic [sdram_sched_pkg::BA_W-1:0]   ba_i,
  output logic [sdram_sched_pkg::BANKS-1:0]  rcd_done_o,
  output logic [sdram_sched_pkg::BANKS-1:0]  bank_ready_o,
  output logic                               rfc_done_o
);

  localparam int TW = sdram_sched_pkg::TIMER_W;

  localparam logic [TW-1:0] RCD_VAL    = TW'(T_RCD);
  localparam logic [TW-1:0] RC_VAL     = TW'(T_RC);
  localparam logic [TW-1:0] RFC_VAL    = TW'(T_RFC);
  localparam logic [TW-1:0] RD_REC_VAL = TW'(T_RP);
  localparam logic [TW-1:0] WR_REC_VAL = TW'(T_WR + T_RP);

  logic [sdram_sched_pkg::BANKS-1:0] ba_dec;
  logic [sdram_sched_pkg::BANKS-1:0] rc_done;
  logic [sdram_sched_pkg::BANKS-1:0] rec_done;
  logic [TW-1:0]                     rec_value;

  assign ba_dec = {{(sdram_sched_pkg::BANKS - 1){1'b0}}, 1'b1} << ba_i;

  // Write recovery comes before the auto-precharge itself
  assign rec_value = is_write_i ? WR_REC_VAL : RD_REC_VAL;

  for (genvar b = 0; b < sdram_sched_pkg::BANKS; b++)
  begin : g_bank
    sdram_timer u_rcd (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .load_i  (act_i & ba_dec[b]),
      .value_i (RCD_VAL),
      .done_o  (rcd_done_o[b])
    );

    sdram_timer u_rc (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .load_i  (act_i & ba_dec[b]),
      .value_i (RC_VAL),
      .done_o  (rc_done[b])
    );

    // Precharge recovery after RD or WR with auto-precharge
    sdram_timer u_rec (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .load_i  (rdwr_i & ba_dec[b]),
      .value_i (rec_value),
      .done_o  (rec_done[b])
    );
  end

  assign bank_ready_o = rc_done & rec_done;

  // Refresh cycle time covers the whole device
  sdram_timer u_rfc (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .load_i  (ref_i),
    .value_i (RFC_VAL),
    .done_o  (rfc_done_o)
  );

endmodule

// ==== src/sdram_cmd_fsm.sv ====
module sdram_cmd_fsm #(
  parameter  int PORTS  = 2,
  parameter  int T_RCD  = 2,
  localparam int PORT_W = (PORTS > 1) ? $clog2(PORTS) : 1
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               grant_valid_i,
  input  logic [PORT_W-1:0]                  grant_port_i,
  input  logic                               grant_we_i,
  input  logic [sdram_sched_pkg::BA_W-1:0]   grant_ba_i,
  input  logic [sdram_sched_pkg::ROW_W-1:0]  grant_row_i,
  input  logic [sdram_sched_pkg::COL_W-1:0]  grant_col_i,
  input  logic [sdram_sched_pkg::DQ_W-1:0]   grant_wdata_i,
  input  logic [sdram_sched_pkg::BANKS-1:0]  bank_ready_i,
  input  logic [sdram_sched_pkg::BANKS-1:0]  rcd_done_i,
  input  logic                               rfc_done_i,
  input  logic                               ref_pending_i,
  output logic                               issued_o,
  output logic                               act_o,
  output logic                               rdwr_o,
  output logic                               is_write_o,
  output logic                               ref_o,
  output logic [sdram_sched_pkg::BA_W-1:0]   cmd_ba_o,
  output logic                               rd_o,
  output logic [PORT_W-1:0]                  rd_port_o,
  output sdram_sched_pkg::sdram_cmd_e        sdram_cmd_o,
  output logic [sdram_sched_pkg::BA_W-1:0]   sdram_ba_o,
  output logic [sdram_sched_pkg::ROW_W-1:0]  sdram_addr_o,
  output logic [sdram_sched_pkg::DQ_W-1:0]   sdram_dq_o,
  output logic                               sdram_dqoe_o
);

  typedef enum logic {
    IDLE,
    ACTIVATED
  } state_e;

  state_e                            state;
  state_e                            nxt_state;
  sdram_sched_pkg::sdram_cmd_e       nxt_cmd;
  logic [sdram_sched_pkg::BA_W-1:0]  nxt_ba;
  logic [sdram_sched_pkg::ROW_W-1:0] nxt_addr;
  logic                              rcd_ok;

  // With tRCD of one cycle the column command may follow ACT directly
  assign rcd_ok = (T_RCD <= 1) || rcd_done_i[grant_ba_i];

  ////////////////////////////////////////////////////////////////////////////
  // Next command decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    nxt_state = state;
    nxt_cmd   = sdram_sched_pkg::NOP;
    nxt_ba    = sdram_ba_o;
    nxt_addr  = sdram_addr_o;
    act_o     = 1'b0;
    rdwr_o    = 1'b0;
    ref_o     = 1'b0;

    case (state)
      IDLE:
      begin
        if (ref_pending_i)
        begin
          // All banks precharged and the previous refresh finished
          if ((&bank_ready_i) && rfc_done_i)
          begin
            nxt_cmd = sdram_sched_pkg::REF;
            ref_o   = 1'b1;
          end
        end
        else if (grant_valid_i && bank_ready_i[grant_ba_i] && rfc_done_i)
        begin
          nxt_cmd   = sdram_sched_pkg::ACT;
          nxt_ba    = grant_ba_i;
          nxt_addr  = grant_row_i;
          act_o     = 1'b1;
          nxt_state = ACTIVATED;
        end
      end

      ACTIVATED:
      begin
        if (rcd_ok)
        begin
          nxt_cmd  = grant_we_i ? sdram_sched_pkg::WR : sdram_sched_pkg::RD;
          nxt_ba   = grant_ba_i;
          nxt_addr = '0;
          nxt_addr[sdram_sched_pkg::COL_W-1:0] = grant_col_i;
          nxt_addr[sdram_sched_pkg::AP_BIT]    = 1'b1;
          rdwr_o    = 1'b1;
          nxt_state = IDLE;
        end
      end
    endcase
  end

  assign issued_o   = rdwr_o;
  assign is_write_o = grant_we_i;
  assign cmd_ba_o   = grant_ba_i;

  ////////////////////////////////////////////////////////////////////////////
  // Registered SDRAM side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state        <= IDLE;
      sdram_cmd_o  <= sdram_sched_pkg::NOP;
      sdram_ba_o   <= '0;
      sdram_addr_o <= '0;
      sdram_dqoe_o <= 1'b0;
      rd_o         <= 1'b0;
      rd_port_o    <= '0;
    end
    else
    begin
      state        <= nxt_state;
      sdram_cmd_o  <= nxt_cmd;
      sdram_ba_o   <= nxt_ba;
      sdram_addr_o <= nxt_addr;
      sdram_dqoe_o <= rdwr_o && grant_we_i;
      // Read tag lines up with RD on the command bus
      rd_o         <= rdwr_o && !grant_we_i;
      rd_port_o    <= grant_port_i;
    end
  end

  // Write beat
  always_ff @(posedge clk_i)
  begin
    if (rdwr_o && grant_we_i)
      sdram_dq_o <= grant_wdata_i;
  end

endmodule

// ==== src/sdram_port_arbiter.sv ====
module sdram_port_arbiter #(
  parameter  int PORTS  = 2,
  localparam int PORT_W = (PORTS > 1) ? $clog2(PORTS) : 1
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [PORTS-1:0]                   req_i,
  input  logic [PORTS-1:0]                   we_i,
  input  logic [sdram_sched_pkg::BA_W-1:0]   ba_i    [PORTS],
  input  logic [sdram_sched_pkg::ROW_W-1:0]  row_i   [PORTS],
  input  logic [sdram_sched_pkg::COL_W-1:0]  col_i   [PORTS],
  input  logic [sdram_sched_pkg::DQ_W-1:0]   wdata_i [PORTS],
  output logic [PORTS-1:0]                   ack_o,
  input  logic                               issued_i,
  output logic                               grant_valid_o,
  output logic [PORT_W-1:0]                  grant_port_o,
  output logic                               grant_we_o,
  output logic [sdram_sched_pkg::BA_W-1:0]   grant_ba_o,
  output logic [sdram_sched_pkg::ROW_W-1:0]  grant_row_o,
  output logic [sdram_sched_pkg::COL_W-1:0]  grant_col_o,
  output logic [sdram_sched_pkg::DQ_W-1:0]   grant_wdata_o
);

  logic [PORTS-1:0]  candidates;
  logic [PORT_W-1:0] pick;

  // Port 0 wins, so scan from the top down
  always_comb
  begin
    candidates = req_i & ~ack_o;
    pick       = '0;
    for (int p = PORTS - 1; p >= 0; p--)
    begin
      if (candidates[p])
        pick = PORT_W'(p);
    end
  end

  // Grant stays locked until the RD or WR of that port is issued
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      grant_valid_o <= 1'b0;
      grant_port_o  <= '0;
    end
    else if (issued_i)
    begin
      grant_valid_o <= 1'b0;
    end
    else if (!grant_valid_o && (candidates != '0))
    begin
      grant_valid_o <= 1'b1;
      grant_port_o  <= pick;
    end
  end

  // Four-phase ack side
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ack_o <= '0;
    end
    else
    begin
      for (int p = 0; p < PORTS; p++)
      begin
        if (ack_o[p])
          ack_o[p] <= req_i[p];  // falls one cycle after req is seen low
        else if (issued_i && (grant_port_o == PORT_W'(p)))
          ack_o[p] <= 1'b1;
      end
    end
  end

  // Clients hold their request fields stable until ack
  assign grant_we_o    = we_i[grant_port_o];
  assign grant_ba_o    = ba_i[grant_port_o];
  assign grant_row_o   = row_i[grant_port_o];
  assign grant_col_o   = col_i[grant_port_o];
  assign grant_wdata_o = wdata_i[grant_port_o];

endmodule

// ==== src/sdram_rd_return.sv ====
module sdram_rd_return #(
  parameter  int PORTS   = 2,
  parameter  int CAS_LAT = 2,
  localparam int PORT_W  = (PORTS > 1) ? $clog2(PORTS) : 1
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             rd_i,
  input  logic [PORT_W-1:0]                rd_port_i,
  input  logic [sdram_sched_pkg::DQ_W-1:0] sdram_dq_i,
  output logic [sdram_sched_pkg::DQ_W-1:0] rdata_o,
  output logic [PORTS-1:0]                 rvalid_o
);

  // One stage per cycle of CAS latency
  logic [CAS_LAT-1:0] stage_valid;
  logic [PORT_W-1:0]  stage_port [CAS_LAT];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      stage_valid <= '0;
      rvalid_o    <= '0;
    end
    else
    begin
      stage_valid[0] <= rd_i;
      for (int s = 1; s < CAS_LAT; s++)
        stage_valid[s] <= stage_valid[s-1];

      // Last stage meets the data on the DQ pins
      rvalid_o <= '0;
      if (stage_valid[CAS_LAT-1])
        rvalid_o[stage_port[CAS_LAT-1]] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    stage_port[0] <= rd_port_i;
    for (int s = 1; s < CAS_LAT; s++)
      stage_port[s] <= stage_port[s-1];
    rdata_o <= sdram_dq_i;
  end

endmodule

// ==== src/sdram_refresh_ctrl.sv ====
module sdram_refresh_ctrl #(
  parameter int REF_INTERVAL = 400
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ref_issued_i,
  output logic ref_pending_o
);

  localparam int               CNT_W = $clog2(REF_INTERVAL);
  localparam logic [CNT_W-1:0] LAST  = CNT_W'(REF_INTERVAL - 1);

  logic [CNT_W-1:0] interval_cnt;
  logic [2:0]       pending;
  logic             tick;
  logic             inc;
  logic             dec;

  assign tick = (interval_cnt == LAST);

  // Free-running interval counter
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      interval_cnt <= '0;
    else if (tick)
      interval_cnt <= '0;
    else
      interval_cnt <= interval_cnt + 1'b1;
  end

  // Count saturates at seven outstanding refreshes
  assign inc = tick && !(&pending);
  assign dec = ref_issued_i && (pending != '0);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      pending <= '0;
    end
    else
    begin
      case ({inc, dec})
        2'b10:   pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
    end
  end

  assign ref_pending_o = (pending != '0);

endmodule

// ==== src/sdram_sched_pkg.sv ====
package sdram_sched_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Device geometry
  ////////////////////////////////////////////////////////////////////////////

  // Bank, row and column address widths
  localparam int BA_W    = 2;
  localparam int ROW_W   = 12;
  localparam int COL_W   = 8;

  // One beat per access
  localparam int DQ_W    = 16;

  localparam int BANKS   = 2 ** BA_W;

  // Address bit that requests auto-precharge on RD and WR
  localparam int AP_BIT  = 10;

  // Every timing counter has this width
  localparam int TIMER_W = 6;

  ////////////////////////////////////////////////////////////////////////////
  // Command encoding
  ////////////////////////////////////////////////////////////////////////////

  // Bits are {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    NOP = 3'b111,
    ACT = 3'b011,
    RD  = 3'b101,
    WR  = 3'b100,
    PRE = 3'b010,
    REF = 3'b001
  } sdram_cmd_e;

endpackage

// ==== src/sdram_sched_top.sv ====
module sdram_sched_top #(
  parameter  int PORTS        = 2,
  parameter  int T_RCD        = 2,
  parameter  int T_RP         = 3,
  parameter  int T_WR         = 2,
  parameter  int T_RC         = 7,
  parameter  int T_RFC        = 8,
  parameter  int CAS_LAT      = 2,
  parameter  int REF_INTERVAL = 400,
  localparam int PORT_W       = (PORTS > 1) ? $clog2(PORTS) : 1
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  // Client ports
  input  logic [PORTS-1:0]                   req_i,
  input  logic [PORTS-1:0]                   we_i,
  input  logic [sdram_sched_pkg::BA_W-1:0]   ba_i    [PORTS],
  input  logic [sdram_sched_pkg::ROW_W-1:0]  row_i   [PORTS],
  input  logic [sdram_sched_pkg::COL_W-1:0]  col_i   [PORTS],
  input  logic [sdram_sched_pkg::DQ_W-1:0]   wdata_i [PORTS],
  output logic [PORTS-1:0]                   ack_o,
  output logic [PORTS-1:0]                   rvalid_o,
  output logic [sdram_sched_pkg::DQ_W-1:0]   rdata_o,

  // SDRAM pins
  output sdram_sched_pkg::sdram_cmd_e        sdram_cmd_o,
  output logic [sdram_sched_pkg::BA_W-1:0]   sdram_ba_o,
  output logic [sdram_sched_pkg::ROW_W-1:0]  sdram_addr_o,
  output logic [sdram_sched_pkg::DQ_W-1:0]   sdram_dq_o,
  output logic                               sdram_dqoe_o,
  input  logic [sdram_sched_pkg::DQ_W-1:0]   sdram_dq_i
);

  logic                              grant_valid;
  logic [PORT_W-1:0]                 grant_port;
  logic                              grant_we;
  logic [sdram_sched_pkg::BA_W-1:0]  grant_ba;
  logic [sdram_sched_pkg::ROW_W-1:0] grant_row;
  logic [sdram_sched_pkg::COL_W-1:0] grant_col;
  logic [sdram_sched_pkg::DQ_W-1:0]  grant_wdata;
  logic                              issued;
  logic                              act_strobe;
  logic                              rdwr_strobe;
  logic                              ref_strobe;
  logic                              is_write;
  logic [sdram_sched_pkg::BA_W-1:0]  cmd_ba;
  logic [sdram_sched_pkg::BANKS-1:0] rcd_done;
  logic [sdram_sched_pkg::BANKS-1:0] bank_ready;
  logic                              rfc_done;
  logic                              ref_pending;
  logic                              rd_strobe;
  logic [PORT_W-1:0]                 rd_port;

  sdram_port_arbiter #(
    .PORTS (PORTS)
  ) u_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .we_i          (we_i),
    .ba_i          (ba_i),
    .row_i         (row_i),
    .col_i         (col_i),
    .wdata_i       (wdata_i),
    .ack_o         (ack_o),
    .issued_i      (issued),
    .grant_valid_o (grant_valid),
    .grant_port_o  (grant_port),
    .grant_we_o    (grant_we),
    .grant_ba_o    (grant_ba),
    .grant_row_o   (grant_row),
    .grant_col_o   (grant_col),
    .grant_wdata_o (grant_wdata)
  );

  sdram_cmd_fsm #(
    .PORTS (PORTS),
    .T_RCD (T_RCD)
  ) u_cmd_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .grant_valid_i (grant_valid),
    .grant_port_i  (grant_port),
    .grant_we_i    (grant_we),
    .grant_ba_i    (grant_ba),
    .grant_row_i   (grant_row),
    .grant_col_i   (grant_col),
    .grant_wdata_i (grant_wdata),
    .bank_ready_i  (bank_ready),
    .rcd_done_i    (rcd_done),
    .rfc_done_i    (rfc_done),
    .ref_pending_i (ref_pending),
    .issued_o      (issued),
    .act_o         (act_strobe),
    .rdwr_o        (rdwr_strobe),
    .is_write_o    (is_write),
    .ref_o         (ref_strobe),
    .cmd_ba_o      (cmd_ba),
    .rd_o          (rd_strobe),
    .rd_port_o     (rd_port),
    .sdram_cmd_o   (sdram_cmd_o),
    .sdram_ba_o    (sdram_ba_o),
    .sdram_addr_o  (sdram_addr_o),
    .sdram_dq_o    (sdram_dq_o),
    .sdram_dqoe_o  (sdram_dqoe_o)
  );

  sdram_bank_timers #(
    .T_RCD (T_RCD),
    .T_RP  (T_RP),
    .T_WR  (T_WR),
    .T_RC  (T_RC),
    .T_RFC (T_RFC)
  ) u_bank_timers (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .act_i        (act_strobe),
    .rdwr_i       (rdwr_strobe),
    .is_write_i   (is_write),
    .ref_i        (ref_strobe),
    .ba_i         (cmd_ba),
    .rcd_done_o   (rcd_done),
    .bank_ready_o (bank_ready),
    .rfc_done_o   (rfc_done)
  );

  sdram_refresh_ctrl #(
    .REF_INTERVAL (REF_INTERVAL)
  ) u_refresh_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ref_issued_i  (ref_strobe),
    .ref_pending_o (ref_pending)
  );

  sdram_rd_return #(
    .PORTS   (PORTS),
    .CAS_LAT (CAS_LAT)
  ) u_rd_return (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_i       (rd_strobe),
    .rd_port_i  (rd_port),
    .sdram_dq_i (sdram_dq_i),
    .rdata_o    (rdata_o),
    .rvalid_o   (rvalid_o)
  );

endmodule

// ==== src/sdram_timer.sv ====
module sdram_timer (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                load_i,
  input  logic [sdram_sched_pkg::TIMER_W-1:0] value_i,
  output logic                                done_o
);

  logic [sdram_sched_pkg::TIMER_W-1:0] count;

  // Expired out of reset so nothing waits on a fresh timer
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      count <= '0;
    end
    else if (load_i)
    begin
      // Load cycle is the first cycle of the interval
      count <= (value_i == '0) ? '0 : value_i - 1'b1;
    end
    else if (count != '0)
    begin
      count <= count - 1'b1;
    end
  end

  assign done_o = (count == '0);

endmodule

// ==== verilog.f ====
src/sdram_sched_pkg.sv
src/sdram_timer.sv
src/sdram_bank_timers.sv
src/sdram_refresh_ctrl.sv
src/sdram_port_arbiter.sv
src/sdram_cmd_fsm.sv
src/sdram_rd_return.sv
src/sdram_sched_top.sv
sim/sdram_model.sv
sim/sdram_sched_asserts.sv
sim/tb_sdram_sched.sv
